// ==== Bender.yml ====
package:
  name: page_table_walker

sources:
  - files:
      - hw/sv39Pkg.sv
      - hw/walkerPkg.sv
      - hw/walkRequest.sv
      - hw/ptAddrGen.sv
      - hw/pteCheck.sv
      - hw/walkControl.sv
      - hw/pageTableWalker.sv
  - target: test
    files:
      - test/pageTableWalker_chk.sv
      - test/pageTableWalker_tb.sv

// ==== all.f ====
hw/sv39Pkg.sv
hw/walkerPkg.sv
hw/walkRequest.sv
hw/ptAddrGen.sv
hw/pteCheck.sv
hw/walkControl.sv
hw/pageTableWalker.sv
test/pageTableWalker_chk.sv
test/pageTableWalker_tb.sv

// ==== hw/pageTableWalker.sv ====
//////////////////////////////////////////////////////////////////////
// Sv39 page table walker
// Serves I-TLB and D-TLB misses with a three-level table walk
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pageTableWalker (
   input  logic                        clk,
   input  logic                        rstN,
   input  logic [sv39Pkg::XLEN-1:0]    satp,
   input  logic [sv39Pkg::XLEN-1:0]    pc,
   input  logic [sv39Pkg::XLEN-1:0]    memAdr,
   input  logic                        itlbMiss,
   input  logic                        dtlbMiss,
   input  logic [1:0]                  memRw,
   input  logic [sv39Pkg::XLEN-1:0]    pteData,
   input  logic                        ptStall,
   output logic [sv39Pkg::PA_BITS-1:0] ptAdrE,
   output logic                        ptReadE,
   output logic [sv39Pkg::PA_BITS-1:0] ptAdrM,
   output logic                        ptReadM,
   output logic                        ptActive,
   output logic [sv39Pkg::XLEN-1:0]    pte,
   output walkerPkg::pageSize          pageType,
   output logic                        itlbWrite,
   output logic                        dtlbWrite,
   output logic                        instrPageFault,
   output logic                        loadPageFault,
   output logic                        storePageFault
);

   // Request to control handshake
   logic walkStart, walkIdle, walkDone;
   logic dataWalk, isStore;

   // Address generation
   logic [sv39Pkg::XLEN-1:0]     vAdr;
   logic [sv39Pkg::PPN_BITS-1:0] basePpn, entryPpn;
   logic [1:0]                   level;
   logic                         addrFromPte;

   // Entry classification
   logic [sv39Pkg::XLEN-1:0] entry;
   logic                     isPointer, isGoodLeaf;

   walkRequest walkRequest_inst (
      .clk, .rstN, .satp, .pc, .memAdr, .itlbMiss, .dtlbMiss, .memRw,
      .walkIdle, .walkDone, .walkStart, .vAdr, .dataWalk, .isStore,
      .ptActive, .basePpn
   );

   ptAddrGen ptAddrGen_inst (
      .clk, .rstN, .vAdr, .basePpn, .entryPpn, .level, .addrFromPte,
      .ptReadE, .ptAdrE, .ptAdrM, .ptReadM
   );

   pteCheck pteCheck_inst (
      .entry, .level, .isStore, .entryPpn, .isPointer, .isGoodLeaf
   );

   walkControl walkControl_inst (
      .clk, .rstN, .walkStart, .ptStall, .pteData, .isPointer, .isGoodLeaf,
      .dataWalk, .isStore, .walkIdle, .walkDone, .level, .addrFromPte,
      .ptReadE, .entry, .pte, .pageType, .itlbWrite, .dtlbWrite,
      .instrPageFault, .loadPageFault, .storePageFault
   );

endmodule

// ==== hw/ptAddrGen.sv ====
//////////////////////////////////////////////////////////////////////
// Page table address generator
// Forms each level's entry address and its memory-stage copy
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ptAddrGen (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic [sv39Pkg::XLEN-1:0]     vAdr,
   input  logic [sv39Pkg::PPN_BITS-1:0] basePpn,
   input  logic [sv39Pkg::PPN_BITS-1:0] entryPpn,
   input  logic [1:0]                   level,
   input  logic                         addrFromPte,
   input  logic                         ptReadE,
   output logic [sv39Pkg::PA_BITS-1:0]  ptAdrE,
   output logic [sv39Pkg::PA_BITS-1:0]  ptAdrM,
   output logic                         ptReadM
);

   logic [sv39Pkg::VPN_BITS-1:0] vpn;
   logic [sv39Pkg::PPN_BITS-1:0] tablePpn;

   // VPN[level] sits above the 4 KiB page offset
   // Page offset width is one table index plus the entry shift
   assign vpn = vAdr[(sv39Pkg::VPN_BITS + sv39Pkg::PTE_SHIFT) + level * sv39Pkg::VPN_BITS
                     +: sv39Pkg::VPN_BITS];

   // Root table comes from satp, lower tables from the last pointer entry
   assign tablePpn = addrFromPte ? entryPpn : basePpn;

   // Entry address, 8-byte aligned
   assign ptAdrE = {tablePpn, vpn, {sv39Pkg::PTE_SHIFT{1'b0}}};

   //////////////////////////////////////////////////////////////////////
   // Memory-stage copy
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      ptAdrM <= ptAdrE;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ptReadM <= 1'b0;
      end else begin
         ptReadM <= ptReadE;
      end
   end

endmodule

// ==== hw/pteCheck.sv ====
//////////////////////////////////////////////////////////////////////
// Page table entry check
// Classifies the held entry as pointer, good leaf or neither
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pteCheck (
   input  logic [sv39Pkg::XLEN-1:0]     entry,
   input  logic [1:0]                   level,
   input  logic                         isStore,
   output logic [sv39Pkg::PPN_BITS-1:0] entryPpn,
   output logic                         isPointer,
   output logic                         isGoodLeaf
);

   logic valid, readable, writable, executable, accessed, dirty;
   logic leafEntry, writeNoRead, accessAlert, misaligned;

   // Unpack flags
   assign valid      = entry[sv39Pkg::PTE_V];
   assign readable   = entry[sv39Pkg::PTE_R];
   assign writable   = entry[sv39Pkg::PTE_W];
   assign executable = entry[sv39Pkg::PTE_X];
   assign accessed   = entry[sv39Pkg::PTE_A];
   assign dirty      = entry[sv39Pkg::PTE_D];

   assign entryPpn = entry[sv39Pkg::PTE_PPN_LSB +: sv39Pkg::PPN_BITS];

   // Any of R, W, X set marks a leaf
   assign leafEntry = readable | writable | executable;

   // W without R is reserved
   assign writeNoRead = writable & ~readable;

   // A clear, or D clear on a store, needs software to update the entry
   assign accessAlert = ~accessed | (isStore & ~dirty);

   // Superpages need the PPN segments below their level to be zero
   always_comb begin
      case (level)
         2'd2:    misaligned = |entryPpn[2*sv39Pkg::VPN_BITS-1:0];
         2'd1:    misaligned = |entryPpn[sv39Pkg::VPN_BITS-1:0];
         default: misaligned = 1'b0;
      endcase
   end

   // No pointer allowed past level 0, so that case falls through to a fault
   assign isPointer = valid & ~leafEntry & (level != 2'd0);

   assign isGoodLeaf = valid & leafEntry & ~writeNoRead & ~accessAlert & ~misaligned;

endmodule

// ==== hw/sv39Pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Sv39 architecture constants
// Address, page number and page table entry layout for RV64 walking
//////////////////////////////////////////////////////////////////////

package sv39Pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   // Register and entry width
   localparam int unsigned XLEN = 64;

   // Physical address and page number
   localparam int unsigned PA_BITS = 56;
   localparam int unsigned PPN_BITS = 44;

   // One VPN segment indexes a 512-entry table
   localparam int unsigned VPN_BITS = 9;
   localparam int unsigned LEVELS = 3;

   // Entry page number starts above the flags and RSW bits
   localparam int unsigned PTE_PPN_LSB = 10;

   // Entries are 8 bytes
   localparam int unsigned PTE_SHIFT = 3;

   //////////////////////////////////////////////////////////////////////
   // satp mode field
   //////////////////////////////////////////////////////////////////////

   // Mode sits in the top bits of satp
   localparam int unsigned SATP_MODE_BITS = 4;
   localparam logic [SATP_MODE_BITS-1:0] MODE_SV39 = 4'd8;

   //////////////////////////////////////////////////////////////////////
   // Entry flag positions
   //////////////////////////////////////////////////////////////////////

   localparam int unsigned PTE_V = 0;
   localparam int unsigned PTE_R = 1;
   localparam int unsigned PTE_W = 2;
   localparam int unsigned PTE_X = 3;
   localparam int unsigned PTE_U = 4;
   localparam int unsigned PTE_G = 5;
   localparam int unsigned PTE_A = 6;
   localparam int unsigned PTE_D = 7;

endpackage

// ==== hw/walkControl.sv ====
//////////////////////////////////////////////////////////////////////
// Walk control
// Walk FSM, entry capture, TLB write and page fault strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module walkControl (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     walkStart,
   input  logic                     ptStall,
   input  logic [sv39Pkg::XLEN-1:0] pteData,
   input  logic                     isPointer,
   input  logic                     isGoodLeaf,
   input  logic                     dataWalk,
   input  logic                     isStore,
   output logic                     walkIdle,
   output logic                     walkDone,
   output logic [1:0]               level,
   output logic                     addrFromPte,
   output logic                     ptReadE,
   output logic [sv39Pkg::XLEN-1:0] entry,
   output logic [sv39Pkg::XLEN-1:0] pte,
   output walkerPkg::pageSize       pageType,
   output logic                     itlbWrite,
   output logic                     dtlbWrite,
   output logic                     instrPageFault,
   output logic                     loadPageFault,
   output logic                     storePageFault
);

   walkerPkg::walkState state, nextState;
   walkerPkg::pageSize  levelSize;
   logic                captureEn, tlbWrite, faultStrobe;

   //////////////////////////////////////////////////////////////////////
   // State and entry registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= walkerPkg::IDLE;
      end else begin
         state <= nextState;
      end
   end

   // Entry is taken on the last cycle of a wait state
   always_ff @(posedge clk) begin
      if (captureEn) begin
         entry <= pteData;
      end
   end

   assign walkIdle = (state == walkerPkg::IDLE);

   //////////////////////////////////////////////////////////////////////
   // Next state and per-state controls
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      nextState   = state;
      level       = 2'(sv39Pkg::LEVELS - 1);
      addrFromPte = 1'b0;
      ptReadE     = 1'b0;
      captureEn   = 1'b0;
      tlbWrite    = 1'b0;
      faultStrobe = 1'b0;
      walkDone    = 1'b0;
      // Level and table source follow the state
      case (state)
         walkerPkg::L1_WAIT, walkerPkg::L1_CHECK: begin
            level       = 2'd1;
            addrFromPte = 1'b1;
         end
         walkerPkg::L0_WAIT, walkerPkg::L0_CHECK: begin
            level       = 2'd0;
            addrFromPte = 1'b1;
         end
         default: begin
         end
      endcase
      case (state)
         walkerPkg::IDLE: begin
            if (walkStart) begin
               nextState = walkerPkg::START;
            end
         end
         walkerPkg::START: nextState = walkerPkg::L2_WAIT;
         // Hold the read until memory stops stalling
         walkerPkg::L2_WAIT, walkerPkg::L1_WAIT, walkerPkg::L0_WAIT: begin
            ptReadE = 1'b1;
            if (!ptStall) begin
               captureEn = 1'b1;
               nextState = walkerPkg::walkState'(state + 4'd1);
            end
         end
         walkerPkg::L2_CHECK, walkerPkg::L1_CHECK, walkerPkg::L0_CHECK: begin
            if (isGoodLeaf) begin
               tlbWrite  = 1'b1;
               nextState = walkerPkg::LEAF;
            end else if (isPointer) begin
               // Next wait state follows this check state
               nextState = walkerPkg::walkState'(state + 4'd1);
            end else begin
               nextState = walkerPkg::FAULT;
            end
         end
         walkerPkg::LEAF: begin
            walkDone  = 1'b1;
            nextState = walkerPkg::IDLE;
         end
         walkerPkg::FAULT: begin
            walkDone    = 1'b1;
            faultStrobe = 1'b1;
            nextState   = walkerPkg::IDLE;
         end
         default: nextState = walkerPkg::IDLE;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Results
   //////////////////////////////////////////////////////////////////////

   // Page size from the level the leaf was found at
   always_comb begin
      case (level)
         2'd2:    levelSize = walkerPkg::PAGE_1G;
         2'd1:    levelSize = walkerPkg::PAGE_2M;
         default: levelSize = walkerPkg::PAGE_4K;
      endcase
   end

   // Result bus only carries data with a write strobe
   assign pte      = tlbWrite ? entry : '0;
   assign pageType = tlbWrite ? levelSize : walkerPkg::PAGE_4K;

   assign itlbWrite = tlbWrite & ~dataWalk;
   assign dtlbWrite = tlbWrite & dataWalk;

   // Fault kind from miss source and access
   assign instrPageFault = faultStrobe & ~dataWalk;
   assign loadPageFault  = faultStrobe & dataWalk & ~isStore;
   assign storePageFault = faultStrobe & dataWalk & isStore;

endmodule

// ==== hw/walkRequest.sv ====
//////////////////////////////////////////////////////////////////////
// Walk request stage
// Arbitrates TLB misses and holds the address and source of a walk
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module walkRequest (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic [sv39Pkg::XLEN-1:0]     satp,
   input  logic [sv39Pkg::XLEN-1:0]     pc,
   input  logic [sv39Pkg::XLEN-1:0]     memAdr,
   input  logic                         itlbMiss,
   input  logic                         dtlbMiss,
   input  logic [1:0]                   memRw,
   input  logic                         walkIdle,
   input  logic                         walkDone,
   output logic                         walkStart,
   output logic [sv39Pkg::XLEN-1:0]     vAdr,
   output logic                         dataWalk,
   output logic                         isStore,
   output logic                         ptActive,
   output logic [sv39Pkg::PPN_BITS-1:0] basePpn
);

   logic [sv39Pkg::SATP_MODE_BITS-1:0] satpMode;
   logic [sv39Pkg::XLEN-1:0]           missAdr;
   logic                               anyMiss;

   // Mode field at the top of satp, root table page at the bottom
   assign satpMode = satp[sv39Pkg::XLEN-1 -: sv39Pkg::SATP_MODE_BITS];
   assign basePpn  = satp[sv39Pkg::PPN_BITS-1:0];

   assign anyMiss = itlbMiss | dtlbMiss;

   // Start only from idle and only with Sv39 translation on
   assign walkStart = walkIdle & anyMiss & (satpMode == sv39Pkg::MODE_SV39);

   // Data miss wins over a pending fetch miss
   assign missAdr = dtlbMiss ? memAdr : pc;

   // Virtual address of the walk
   always_ff @(posedge clk) begin
      if (walkStart) begin
         vAdr <= missAdr;
      end
   end

   // Miss source and access kind, held for the fault and write strobes
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         dataWalk <= 1'b0;
         isStore  <= 1'b0;
         ptActive <= 1'b0;
      end else if (walkStart) begin
         dataWalk <= dtlbMiss;
         // Store only matters for a data walk
         isStore  <= dtlbMiss & memRw[0];
         ptActive <= 1'b1;
      end else if (walkDone) begin
         dataWalk <= 1'b0;
         isStore  <= 1'b0;
         ptActive <= 1'b0;
      end
   end

endmodule

// ==== hw/walkerPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Walker encodings
// FSM state encoding and TLB page-size codes
//////////////////////////////////////////////////////////////////////

package walkerPkg;

   // Walk FSM states
   // Each level has a wait state for the read and a check state
   typedef enum logic [3:0] {
      IDLE,
      START,
      L2_WAIT,
      L2_CHECK,
      L1_WAIT,
      L1_CHECK,
      L0_WAIT,
      L0_CHECK,
      LEAF,
      FAULT
   } walkState;

   // Page size handed to the TLB with the entry
   // Code follows the level the leaf was found at
   typedef enum logic [1:0] {
      PAGE_4K = 2'd0,
      PAGE_2M = 2'd1,
      PAGE_1G = 2'd2
   } pageSize;

endpackage

// ==== test/pageTableWalker_chk.sv ====
//////////////////////////////////////////////////////////////////////
// Page table walker protocol checks
// Read hold under stall, memory-stage copy and strobe rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pageTableWalker_chk (
   input logic                        clk,
   input logic                        rstN,
   input logic [sv39Pkg::PA_BITS-1:0] ptAdrE,
   input logic                        ptReadE,
   input logic [sv39Pkg::PA_BITS-1:0] ptAdrM,
   input logic                        ptReadM,
   input logic                        ptStall,
   input logic                        ptActive,
   input logic                        itlbWrite,
   input logic                        dtlbWrite,
   input logic                        instrPageFault,
   input logic                        loadPageFault,
   input logic                        storePageFault
);

   logic [4:0] strobes;

   // Number of failed assertions
   int assertFails = 0;

   assign strobes = {itlbWrite, dtlbWrite, instrPageFault, loadPageFault, storePageFault};

   // Read address holds while memory stalls
   readHold: assert property (@(posedge clk) disable iff (!rstN)
      ptReadE && ptStall |=> $stable(ptAdrE))
      else begin
         $error("ptAdrE moved during a stalled read");
         assertFails++;
      end

   // Memory-stage copies lag the E stage by one cycle
   readCopy: assert property (@(posedge clk) disable iff (!rstN)
      ptReadM == $past(ptReadE))
      else begin
         $error("ptReadM is not the previous ptReadE");
         assertFails++;
      end

   adrCopy: assert property (@(posedge clk) disable iff (!rstN)
      ptReadM |-> ptAdrM == $past(ptAdrE))
      else begin
         $error("ptAdrM is not the previous ptAdrE");
         assertFails++;
      end

   // One result per walk, and only inside a walk
   oneStrobe: assert property (@(posedge clk) disable iff (!rstN) $onehot0(strobes))
      else begin
         $error("more than one write or fault strobe at once");
         assertFails++;
      end

   activeStrobe: assert property (@(posedge clk) disable iff (!rstN)
      !ptActive |-> strobes == 5'b0)
      else begin
         $error("strobe while no walk is active");
         assertFails++;
      end

endmodule

// ==== test/pageTableWalker_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Page table walker testbench
// Table-driven walks against a stalling entry memory model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pageTableWalker_tb;

   // Result kinds
   localparam int K_NONE = 0;
   localparam int K_ITLB = 1;
   localparam int K_DTLB = 2;
   localparam int K_IPF  = 3;
   localparam int K_LPF  = 4;
   localparam int K_SPF  = 5;

   localparam int NUM_ROWS  = 13;
   localparam int MAX_STALL = 3;
   // START, three levels of wait plus check, result and return to idle
   localparam int WALK_MAX    = 1 + 3 * (MAX_STALL + 2) + 2;
   localparam int CYCLE_LIMIT = 10 + NUM_ROWS * (2 * WALK_MAX + 4);

   localparam logic [3:0]  MODE_ON  = sv39Pkg::MODE_SV39;
   localparam logic [43:0] ROOT_PPN = 44'h00080;
   localparam logic [63:0] PC_XOR   = 64'h0000_0020_0060_3000;

   // Entry fields from the top are reserved bits, PPN, RSW and flags
   localparam logic [63:0] PTR2    = {10'h0, 44'h01000, 10'h001};
   localparam logic [63:0] PTR1    = {10'h0, 44'h02000, 10'h001};
   localparam logic [63:0] LEAF4K  = {10'h0, 44'h03456, 10'h0CF};
   localparam logic [63:0] MEGA    = {10'h0, 44'h05200, 10'h0CF};
   localparam logic [63:0] MEGABAD = {10'h0, 44'h05201, 10'h0CF};
   localparam logic [63:0] GIGA    = {10'h0, 44'hC0000, 10'h0CF};
   localparam logic [63:0] GIGABAD = {10'h0, 44'hC0200, 10'h0CF};
   // Bad leaves with W without R, A clear or D clear
   localparam logic [63:0] WNR     = {10'h0, 44'h03456, 10'h0C5};
   localparam logic [63:0] NOA     = {10'h0, 44'h03456, 10'h00B};
   localparam logic [63:0] NOD     = {10'h0, 44'h03456, 10'h047};

   localparam logic [63:0] VA_A = 64'h0000_0012_3456_7000;
   localparam logic [63:0] VA_B = 64'h0000_0040_1FF8_3000;
   localparam logic [63:0] VA_C = 64'h0000_003F_C020_1ABC;

   typedef struct {
      bit                 dataMiss;
      bit                 instrMiss;
      bit                 store;
      logic [3:0]         mode;
      logic [63:0]        va;
      logic [63:0]        ent [3];
      int                 kind;
      logic [63:0]        expPte;
      walkerPkg::pageSize expType;
   } stimRow;

   logic                        clk;
   logic                        rstN;
   logic [sv39Pkg::XLEN-1:0]    satp;
   logic [sv39Pkg::XLEN-1:0]    pc;
   logic [sv39Pkg::XLEN-1:0]    memAdr;
   logic                        itlbMiss;
   logic                        dtlbMiss;
   logic [1:0]                  memRw;
   logic [sv39Pkg::XLEN-1:0]    pteData;
   logic                        ptStall;
   logic [sv39Pkg::PA_BITS-1:0] ptAdrE;
   logic                        ptReadE;
   logic [sv39Pkg::PA_BITS-1:0] ptAdrM;
   logic                        ptReadM;
   logic                        ptActive;
   logic [sv39Pkg::XLEN-1:0]    pte;
   walkerPkg::pageSize          pageType;
   logic                        itlbWrite;
   logic                        dtlbWrite;
   logic                        instrPageFault;
   logic                        loadPageFault;
   logic                        storePageFault;
   logic [4:0]                  strobes;

   stimRow      rows [NUM_ROWS];
   stimRow      cur;
   logic [63:0] curVa;
   logic [43:0] tablePpn;
   logic [31:0] rnd = 32'h1930;
   int          readCnt = 0;
   int          readLevel;
   int          stallRun = 0;
   int          cycleCount = 0;
   int          errors = 0;
   int          checks = 0;

   assign strobes = {itlbWrite, dtlbWrite, instrPageFault, loadPageFault, storePageFault};

   pageTableWalker pageTableWalker_inst (
      .clk, .rstN, .satp, .pc, .memAdr, .itlbMiss, .dtlbMiss, .memRw, .pteData,
      .ptStall, .ptAdrE, .ptReadE, .ptAdrM, .ptReadM, .ptActive, .pte, .pageType,
      .itlbWrite, .dtlbWrite, .instrPageFault, .loadPageFault, .storePageFault
   );

   bind pageTableWalker pageTableWalker_chk pageTableWalker_chk_inst (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic checkPte(input logic [sv39Pkg::XLEN-1:0] got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: pte %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic checkPageType(input walkerPkg::pageSize got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: pageType %s, expected %s", $time, got.name(), exp.name());
      end
   endtask

   task automatic checkAdr(input logic [sv39Pkg::PA_BITS-1:0] got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: ptAdrE %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic checkFault(input logic [2:0] got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: faults i/l/s %b, expected %b", $time, got, exp);
      end
   endtask

   task automatic checkWrite(input logic [1:0] got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: writes i/d %b, expected %b", $time, got, exp);
      end
   endtask

   // Wait for the walk's result strobe, check it, then the TLB drops its miss
   task automatic finishWalk(input int kind);
      logic [4:0] expStrobes;
      expStrobes = 5'b10000 >> (kind - 1);
      @(negedge clk);
      while (strobes == 5'b0) @(negedge clk);
      checkWrite(strobes[4:3], expStrobes[4:3]);
      checkFault(strobes[2:0], expStrobes[2:0]);
      if (kind == K_ITLB || kind == K_DTLB) begin
         checkPte(pte, cur.expPte);
         checkPageType(pageType, cur.expType);
      end
      readCnt = 0;
      @(posedge clk);
      if (kind == K_ITLB || kind == K_IPF) begin
         itlbMiss <= 1'b0;
      end else begin
         dtlbMiss <= 1'b0;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Memory model
   //////////////////////////////////////////////////////////////////////

   // Random stalls with a capped run length
   // Entry data for the next level to read
   always @(posedge clk) begin
      rnd = xorshift(rnd);
      if (stallRun < MAX_STALL && rnd[1:0] == 2'b00) begin
         ptStall <= 1'b1;
         stallRun++;
      end else begin
         ptStall <= 1'b0;
         stallRun = 0;
      end
      pteData <= (readCnt < 3) ? cur.ent[2 - readCnt] : '0;
   end

   // A completed read addresses the table PPN, the level's VPN and an 8-byte entry
   always @(negedge clk) begin
      if (rstN && ptReadE && !ptStall) begin
         if (readCnt > 2) begin
            errors++;
            $display("More than three entry reads in one walk at %0t", $time);
         end else begin
            readLevel = 2 - readCnt;
            tablePpn = (readLevel == 2) ? ROOT_PPN : cur.ent[readLevel + 1][53:10];
            checkAdr(ptAdrE, {tablePpn, curVa[12 + 9 * readLevel +: 9], 3'b000});
            readCnt++;
         end
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT) begin
         $display("Timeout: walks not finished after %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus table and main loop
   //////////////////////////////////////////////////////////////////////

   initial begin
      // Entries listed level 0, level 1, level 2
      rows[0]  = '{1, 0, 0, MODE_ON, VA_A, '{LEAF4K, PTR1, PTR2},
                   K_DTLB, LEAF4K, walkerPkg::PAGE_4K};
      rows[1]  = '{1, 0, 1, MODE_ON, VA_B, '{LEAF4K, PTR1, PTR2},
                   K_DTLB, LEAF4K, walkerPkg::PAGE_4K};
      rows[2]  = '{1, 0, 0, MODE_ON, VA_C, '{0, MEGA, PTR2}, K_DTLB, MEGA, walkerPkg::PAGE_2M};
      rows[3]  = '{1, 0, 0, MODE_ON, VA_A, '{0, MEGABAD, PTR2}, K_LPF, 0, walkerPkg::PAGE_4K};
      rows[4]  = '{0, 1, 0, MODE_ON, VA_B, '{0, 0, GIGA}, K_ITLB, GIGA, walkerPkg::PAGE_1G};
      rows[5]  = '{0, 1, 0, MODE_ON, VA_C, '{0, 0, GIGABAD}, K_IPF, 0, walkerPkg::PAGE_4K};
      // Both TLBs miss and the data walk goes first
      rows[6]  = '{1, 1, 0, MODE_ON, VA_A, '{LEAF4K, PTR1, PTR2},
                   K_DTLB, LEAF4K, walkerPkg::PAGE_4K};
      rows[7]  = '{1, 0, 0, MODE_ON, VA_B, '{0, 0, 0}, K_LPF, 0, walkerPkg::PAGE_4K};
      rows[8]  = '{1, 0, 1, MODE_ON, VA_C, '{WNR, PTR1, PTR2}, K_SPF, 0, walkerPkg::PAGE_4K};
      rows[9]  = '{0, 1, 0, MODE_ON, VA_A, '{NOA, PTR1, PTR2}, K_IPF, 0, walkerPkg::PAGE_4K};
      rows[10] = '{1, 0, 1, MODE_ON, VA_B, '{NOD, PTR1, PTR2}, K_SPF, 0, walkerPkg::PAGE_4K};
      // Pointer at level 0
      rows[11] = '{1, 0, 0, MODE_ON, VA_C, '{PTR1, PTR1, PTR2}, K_LPF, 0, walkerPkg::PAGE_4K};
      // Translation off
      rows[12] = '{1, 0, 0, 4'd0, VA_A, '{LEAF4K, PTR1, PTR2}, K_NONE, 0, walkerPkg::PAGE_4K};

      satp     = '0;
      pc       = '0;
      memAdr   = '0;
      itlbMiss = 1'b0;
      dtlbMiss = 1'b0;
      memRw    = 2'b00;
      pteData  = '0;
      ptStall  = 1'b0;
      rstN     = 1'b0;
      repeat (10) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);

      for (int r = 0; r < NUM_ROWS; r++) begin
         cur = rows[r];
         curVa = cur.va;
         readCnt = 0;
         @(posedge clk);
         satp     <= {cur.mode, 16'h0, ROOT_PPN};
         memAdr   <= cur.va;
         pc       <= cur.dataMiss ? cur.va ^ PC_XOR : cur.va;
         memRw    <= {~cur.store, cur.store};
         dtlbMiss <= cur.dataMiss;
         itlbMiss <= cur.instrMiss;
         if (cur.kind == K_NONE) begin
            repeat (WALK_MAX) begin
               @(negedge clk);
               if (ptReadE || ptActive || strobes != 5'b0) begin
                  errors++;
                  $display("CHECK FAILED at %0t: walk activity with translation off", $time);
               end
            end
            @(posedge clk);
            dtlbMiss <= 1'b0;
            itlbMiss <= 1'b0;
         end else begin
            finishWalk(cur.kind);
            // Fetch walk waits behind the data walk
            if (cur.dataMiss && cur.instrMiss) begin
               curVa = cur.va ^ PC_XOR;
               finishWalk(cur.kind == K_DTLB ? K_ITLB : K_IPF);
            end
         end
         @(negedge clk);
      end

      $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
               pageTableWalker_inst.pageTableWalker_chk_inst.assertFails);
      if (errors == 0 && pageTableWalker_inst.pageTableWalker_chk_inst.assertFails == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
